//--- source/cfgo_cfg.svh
`ifndef CFGO_CFG_SVH
`define CFGO_CFG_SVH

// I/O window base, low 3 bits must stay zero
`define CFGO_IO_BASE 8'h40

// Config bus address width
`define CFGO_ADDR_W 16

// Config bus data width, four staged bytes
`define CFGO_DATA_W 32

`endif

//--- source/cfgo_pkg.sv
`include "cfgo_cfg.svh"

package cfgo_pkg;

  // Bit positions of the one-hot engine state
  localparam int s_idle  = 0;
  localparam int s_write = 1;
  localparam int s_read  = 2;
  localparam int s_ack   = 3;

  // Register at each offset of the I/O window
  typedef enum logic [2:0] {
    ADDR0  = 3'd0,
    ADDR1  = 3'd1,
    DATA0  = 3'd2,
    DATA1  = 3'd3,
    DATA2  = 3'd4,
    DATA3  = 3'd5,
    STATUS = 3'd6,
    RSVD   = 3'd7
  } reg_sel_e;

  typedef struct packed {
    logic       start;                  // First cycle of a window access
    logic       active;                 // Whole access
    logic       write;                  // From wr_n
    reg_sel_e   sel;                    // Offset within window
    logic [7:0] wdata;                  // Processor write byte
  } io_acc_t;

  typedef struct packed {
    logic                    wr_go;     // Start config write
    logic                    rd_go;     // Start config read
    logic [`CFGO_ADDR_W-1:0] addr;      // Staged address
    logic [`CFGO_DATA_W-1:0] wdata;     // Staged data word
  } cfg_cmd_t;

  typedef struct packed {
    logic                    irdy;
    logic                    write;
    logic [`CFGO_ADDR_W-1:0] addr;
    logic [`CFGO_DATA_W-1:0] wdata;
  } cfg_req_t;

  typedef struct packed {
    logic                    trdy;
    logic [`CFGO_DATA_W-1:0] rdata;
  } cfg_rsp_t;

  typedef struct packed {
    logic [3:0]              state;     // One-hot idle/write/read/ack
    logic [`CFGO_DATA_W-1:0] hold;      // Last word sent or received
  } eng_stat_t;

endpackage

//--- source/io_port_decode.sv
`timescale 1ns/10ps
`include "cfgo_cfg.svh"

module io_port_decode (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic [15:0]           addr,
  input  logic [7:0]            cd_wdata,
  input  logic                  rd_n,
  input  logic                  wr_n,
  input  logic                  iorq_n,
  output cfgo_pkg::io_acc_t     io_acc
);

  localparam logic [7:0] io_base = `CFGO_IO_BASE;

  logic base_hit;                       // Port address inside the 8-byte window
  logic strobe;                         // Read or write strobe present
  logic in_win;
  logic in_win_q;                       // Window hit one cycle ago

  // Only the low byte carries the port number on the Z80 I/O cycle
  assign base_hit = (addr[7:3] == io_base[7:3]);

  // Interrupt acknowledge drives iorq_n with neither strobe, so it is ignored
  assign strobe = ~rd_n | ~wr_n;
  assign in_win = ~iorq_n & strobe & base_hit;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      in_win_q <= 1'b0;
    end
    else
    begin
      in_win_q <= in_win;
    end
  end

  assign io_acc.start  = in_win & ~in_win_q;            // Rising edge of the hit
  assign io_acc.active = in_win;
  assign io_acc.write  = ~wr_n;
  assign io_acc.sel    = cfgo_pkg::reg_sel_e'(addr[2:0]); // Offset into window
  assign io_acc.wdata  = cd_wdata;

  // Each access needs iorq_n to go high before the next one starts
  a_start_single: assert property (
    @(posedge clk) disable iff (!reset_n)
    io_acc.start |=> !io_acc.start
  ) else $error("io_port_decode: start asserted on consecutive cycles");

endmodule

//--- source/cfgo_reg_file.sv
`timescale 1ns/10ps

module cfgo_reg_file (
  input  logic                  clk,
  input  logic                  reset_n,
  input  cfgo_pkg::io_acc_t     io_acc,
  input  cfgo_pkg::eng_stat_t   eng,
  output cfgo_pkg::cfg_cmd_t    cfg_cmd,
  output logic                  pending
);

  logic       idle;                     // Engine can take a command
  logic       is_reg;                   // Access touches address or data
  logic       pend_set;                 // Access starts on a busy engine
  logic       pend_q;                   // Held access waiting for idle
  logic       take;                     // Access takes effect this cycle
  logic       wr_take;
  logic [7:0] addr0_q;
  logic [7:0] addr1_q;
  logic [7:0] data0_q;
  logic [7:0] data1_q;
  logic [7:0] data2_q;
  logic [7:0] data3_q;

  assign idle = eng.state[cfgo_pkg::s_idle];

  // STATUS and RSVD never wait on the engine
  assign is_reg = (io_acc.sel != cfgo_pkg::STATUS) && (io_acc.sel != cfgo_pkg::RSVD);

  assign pend_set = io_acc.start & is_reg & ~idle;

  // Either a fresh access on an idle engine or a held one released
  assign take    = idle & io_acc.active & (io_acc.start | pend_q);
  assign wr_take = take & io_acc.write;

  // Stays high from the start cycle until the release cycle
  assign pending = pend_set | (pend_q & ~idle & io_acc.active);

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      pend_q <= 1'b0;
    end
    else if (pend_set)
    begin
      pend_q <= 1'b1;
    end
    else if (take || !io_acc.active)
    begin
      pend_q <= 1'b0;                   // Released or processor gave up
    end
  end

  // Staging registers, one byte per window offset
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      addr0_q <= 8'h00;
      addr1_q <= 8'h00;
      data0_q <= 8'h00;
      data1_q <= 8'h00;
      data2_q <= 8'h00;
      data3_q <= 8'h00;
    end
    else if (wr_take)
    begin
      case (io_acc.sel)
        cfgo_pkg::ADDR0: addr0_q <= io_acc.wdata;
        cfgo_pkg::ADDR1: addr1_q <= io_acc.wdata;
        cfgo_pkg::DATA0: data0_q <= io_acc.wdata;
        cfgo_pkg::DATA1: data1_q <= io_acc.wdata;
        cfgo_pkg::DATA2: data2_q <= io_acc.wdata;
        cfgo_pkg::DATA3: data3_q <= io_acc.wdata;
        default: ;                      // STATUS read-only, RSVD ignored
      endcase
    end
  end

  // DATA3 write fires the cycle, DATA0 read fetches the word
  assign cfg_cmd.wr_go = wr_take & (io_acc.sel == cfgo_pkg::DATA3);
  assign cfg_cmd.rd_go = take & ~io_acc.write & (io_acc.sel == cfgo_pkg::DATA0);
  assign cfg_cmd.addr  = {addr1_q, addr0_q};

  // Top byte bypasses its register so the word is whole on wr_go
  assign cfg_cmd.wdata = {(cfg_cmd.wr_go ? io_acc.wdata : data3_q),
                          data2_q, data1_q, data0_q};

  a_go_excl: assert property (
    @(posedge clk) disable iff (!reset_n)
    !(cfg_cmd.wr_go && cfg_cmd.rd_go)
  ) else $error("cfgo_reg_file: wr_go and rd_go together");

endmodule

//--- source/cfgo_txn_engine.sv
`timescale 1ns/10ps

module cfgo_txn_engine (
  input  logic                  clk,
  input  logic                  reset_n,
  input  cfgo_pkg::cfg_cmd_t    cfg_cmd,
  output cfgo_pkg::cfg_req_t    cfg_req,
  input  cfgo_pkg::cfg_rsp_t    cfg_rsp,
  output cfgo_pkg::eng_stat_t   eng
);

  localparam logic [3:0] st_idle  = 4'b0001 << cfgo_pkg::s_idle;
  localparam logic [3:0] st_write = 4'b0001 << cfgo_pkg::s_write;
  localparam logic [3:0] st_read  = 4'b0001 << cfgo_pkg::s_read;
  localparam logic [3:0] st_ack   = 4'b0001 << cfgo_pkg::s_ack;

  logic [3:0]  state_q;
  logic [3:0]  state_d;
  logic [31:0] hold_q;                  // Write word out, read word in
  logic [15:0] addr_q;                  // Address for the running cycle
  logic        go;

  assign go = cfg_cmd.wr_go | cfg_cmd.rd_go;

  always_comb
  begin
    state_d = state_q;
    case (1'b1)
      state_q[cfgo_pkg::s_idle]:
      begin
        if (cfg_cmd.rd_go)
          state_d = st_read;
        else if (cfg_cmd.wr_go)
          state_d = st_write;
      end
      state_q[cfgo_pkg::s_write]:
      begin
        if (cfg_rsp.trdy)
          state_d = st_idle;            // Data taken, done
      end
      state_q[cfgo_pkg::s_read]:
      begin
        if (cfg_rsp.trdy)
          state_d = st_ack;
      end
      state_q[cfgo_pkg::s_ack]:
      begin
        state_d = st_idle;              // Single cycle for wait_n release
      end
      default:
      begin
        state_d = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state_q <= st_idle;
      hold_q  <= '0;
      addr_q  <= '0;
    end
    else
    begin
      state_q <= state_d;
      if (state_q[cfgo_pkg::s_idle] && go)
        addr_q <= cfg_cmd.addr;         // Latch target address
      if (state_q[cfgo_pkg::s_idle] && cfg_cmd.wr_go)
        hold_q <= cfg_cmd.wdata;        // Word to send
      else if (state_q[cfgo_pkg::s_read] && cfg_rsp.trdy)
        hold_q <= cfg_rsp.rdata;        // Word returned by target
    end
  end

  // Request held steady by the registers until trdy
  assign cfg_req.irdy  = state_q[cfgo_pkg::s_write] | state_q[cfgo_pkg::s_read];
  assign cfg_req.write = state_q[cfgo_pkg::s_write];
  assign cfg_req.addr  = addr_q;
  assign cfg_req.wdata = hold_q;

  assign eng.state = state_q;
  assign eng.hold  = hold_q;

  a_state_onehot: assert property (
    @(posedge clk) disable iff (!reset_n)
    $onehot(state_q)
  ) else $error("cfgo_txn_engine: state not one-hot %b", state_q);

  // No target may see the request change before it answers
  a_req_stable: assert property (
    @(posedge clk) disable iff (!reset_n)
    (cfg_req.irdy && !cfg_rsp.trdy) |=>
      (cfg_req.irdy && $stable(cfg_req.write) && $stable(cfg_req.addr) &&
       $stable(cfg_req.wdata))
  ) else $error("cfgo_txn_engine: request changed while waiting on trdy");

endmodule

//--- source/io_readback.sv
`timescale 1ns/10ps

module io_readback (
  input  logic                  clk,
  input  logic                  reset_n,
  input  cfgo_pkg::io_acc_t     io_acc,
  input  logic                  pending,
  input  cfgo_pkg::eng_stat_t   eng,
  input  logic [47:0]           staged,
  output logic [7:0]            cd_rdata,
  output logic                  wait_n
);

  logic ack;
  logic data0_rd;                       // Start of a DATA0 read
  logic rd_wait_q;                      // DATA0 read still waiting on engine
  logic rd_wait;

  assign ack      = eng.state[cfgo_pkg::s_ack];
  assign data0_rd = io_acc.start & ~io_acc.write & (io_acc.sel == cfgo_pkg::DATA0);

  // A held read keeps the flag through the ack of the earlier cycle
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      rd_wait_q <= 1'b0;
    end
    else if (data0_rd)
    begin
      rd_wait_q <= 1'b1;
    end
    else if (!io_acc.active || (ack && !pending))
    begin
      rd_wait_q <= 1'b0;
    end
  end

  assign rd_wait = data0_rd | rd_wait_q;

  // Released in the ack cycle, so hold is valid at the sampling edge
  assign wait_n = ~((rd_wait & ~ack) | pending);

  always_comb
  begin
    cd_rdata = 8'h00;                   // Outside window or RSVD
    if (io_acc.active)
    begin
      case (io_acc.sel)
        cfgo_pkg::ADDR0:  cd_rdata = staged[39:32];
        cfgo_pkg::ADDR1:  cd_rdata = staged[47:40];
        cfgo_pkg::DATA0:  cd_rdata = eng.hold[7:0];
        cfgo_pkg::DATA1:  cd_rdata = eng.hold[15:8];
        cfgo_pkg::DATA2:  cd_rdata = eng.hold[23:16];
        cfgo_pkg::DATA3:  cd_rdata = eng.hold[31:24];
        cfgo_pkg::STATUS: cd_rdata = {4'h0, eng.state};
        default:          cd_rdata = 8'h00;
      endcase
    end
  end

endmodule

//--- source/cfgo_bridge_top.sv
`timescale 1ns/10ps

module cfgo_bridge_top (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic [15:0]           addr,
  input  logic [7:0]            cd_wdata,
  input  logic                  rd_n,
  input  logic                  wr_n,
  input  logic                  iorq_n,
  output logic [7:0]            cd_rdata,
  output logic                  wait_n,
  output cfgo_pkg::cfg_req_t    cfg_req,
  input  cfgo_pkg::cfg_rsp_t    cfg_rsp
);

  cfgo_pkg::io_acc_t   io_acc;        // Decoded processor access
  cfgo_pkg::cfg_cmd_t  cfg_cmd;       // Go strobes and staged payload
  cfgo_pkg::eng_stat_t eng;           // Engine state and hold word
  logic                pending;
  logic [47:0]         staged;        // Address over data bytes

  assign staged = {cfg_cmd.addr, cfg_cmd.wdata};

  io_port_decode u_decode (
    .clk      (clk),
    .reset_n  (reset_n),
    .addr     (addr),
    .cd_wdata (cd_wdata),
    .rd_n     (rd_n),
    .wr_n     (wr_n),
    .iorq_n   (iorq_n),
    .io_acc   (io_acc)
  );

  cfgo_reg_file u_regs (
    .clk      (clk),
    .reset_n  (reset_n),
    .io_acc   (io_acc),
    .eng      (eng),
    .cfg_cmd  (cfg_cmd),
    .pending  (pending)
  );

  cfgo_txn_engine u_engine (
    .clk      (clk),
    .reset_n  (reset_n),
    .cfg_cmd  (cfg_cmd),
    .cfg_req  (cfg_req),
    .cfg_rsp  (cfg_rsp),
    .eng      (eng)
  );

  io_readback u_readback (
    .clk      (clk),
    .reset_n  (reset_n),
    .io_acc   (io_acc),
    .pending  (pending),
    .eng      (eng),
    .staged   (staged),
    .cd_rdata (cd_rdata),
    .wait_n   (wait_n)
  );

endmodule

//--- test/cfg_target_model.sv
`timescale 1ns/10ps

module cfg_target_model (
  input  logic                  clk,
  input  logic                  reset_n,
  input  cfgo_pkg::cfg_req_t    cfg_req,
  output cfgo_pkg::cfg_rsp_t    cfg_rsp,
  input  logic [3:0]            trdy_delay,   // Cycles of irdy before trdy
  output int                    wr_count,
  output int                    rd_count,
  output logic [15:0]           last_addr,    // Last written address
  output logic [31:0]           last_wdata
);

  logic [31:0] mem [0:255];                   // Indexed by addr[7:0]
  logic [3:0]  wait_cnt;
  logic        xfer;                          // Data phase this cycle

  assign cfg_rsp.trdy  = cfg_req.irdy && (wait_cnt >= trdy_delay);
  assign cfg_rsp.rdata = mem[cfg_req.addr[7:0]];
  assign xfer          = cfg_req.irdy & cfg_rsp.trdy;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      wait_cnt <= 4'd0;
    else if (xfer)
      wait_cnt <= 4'd0;                       // Ready for the next request
    else if (cfg_req.irdy && wait_cnt != 4'hf)
      wait_cnt <= wait_cnt + 4'd1;
  end

  // Fill pattern uses every address bit
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      for (int i = 0; i < 256; i++)
        mem[i] <= {i[7:0] ^ 8'h96, ~i[7:0], i[7:0] + 8'h2d, i[7:0]};
    end
    else if (xfer && cfg_req.write)
    begin
      mem[cfg_req.addr[7:0]] <= cfg_req.wdata;
    end
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      wr_count   <= 0;
      rd_count   <= 0;
      last_addr  <= 16'h0000;
      last_wdata <= 32'h0000_0000;
    end
    else if (xfer)
    begin
      if (cfg_req.write)
      begin
        wr_count   <= wr_count + 1;
        last_addr  <= cfg_req.addr;
        last_wdata <= cfg_req.wdata;
      end
      else
      begin
        rd_count <= rd_count + 1;
      end
    end
  end

endmodule

//--- test/cfgo_bridge_tb.sv
`timescale 1ns/10ps
`include "cfgo_cfg.svh"

module cfgo_bridge_tb;

  localparam int max_acc  = 300;              // Accesses over all tests
  localparam int worst_cy = 44;               // Held behind a slow write, then own read
  localparam int limit_ns = (max_acc * worst_cy + 16 + 100) * 20;

  typedef struct packed {
    logic [15:0] port;
    logic [7:0]  got;
    logic [7:0]  exp;
  } rd_rec_t;

  logic               clk = 1'b0;
  logic               reset_n;
  logic [15:0]        addr;
  logic [7:0]         cd_wdata;
  logic               rd_n;
  logic               wr_n;
  logic               iorq_n;
  logic [7:0]         cd_rdata;
  logic               wait_n;
  cfgo_pkg::cfg_req_t cfg_req;
  cfgo_pkg::cfg_rsp_t cfg_rsp;
  logic [3:0]         trdy_delay;
  int                 wr_count;
  int                 rd_count;
  logic [15:0]        last_addr;
  logic [31:0]        last_wdata;

  logic [31:0] lfsr = 32'h25cb1946;
  logic [31:0] m_mem [0:255];                 // Target memory as the model sees it
  logic [15:0] m_addr;
  logic [31:0] m_data;                        // Staged DATA3..DATA0
  logic [31:0] m_hold;
  rd_rec_t     results[$];
  event        result_ev;
  int          errors = 0;
  int          checks = 0;
  int          test_err = 0;

  cfgo_bridge_top UUT (
    .clk      (clk),
    .reset_n  (reset_n),
    .addr     (addr),
    .cd_wdata (cd_wdata),
    .rd_n     (rd_n),
    .wr_n     (wr_n),
    .iorq_n   (iorq_n),
    .cd_rdata (cd_rdata),
    .wait_n   (wait_n),
    .cfg_req  (cfg_req),
    .cfg_rsp  (cfg_rsp)
  );

  cfg_target_model target (
    .clk        (clk),
    .reset_n    (reset_n),
    .cfg_req    (cfg_req),
    .cfg_rsp    (cfg_rsp),
    .trdy_delay (trdy_delay),
    .wr_count   (wr_count),
    .rd_count   (rd_count),
    .last_addr  (last_addr),
    .last_wdata (last_wdata)
  );

  always #10 clk = ~clk;

  // Galois LFSR, one step per bit
  function automatic logic rand_bit();
    rand_bit = lfsr[0];
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
  endfunction

  function automatic logic [3:0] rand_nib();
    return {rand_bit(), rand_bit(), rand_bit(), rand_bit()};
  endfunction

  function automatic logic [7:0] rand_byte();
    logic [7:0] b;
    for (int i = 0; i < 8; i++)
      b[i] = rand_bit();
    return b;
  endfunction

  // Same reset fill as the target model
  function automatic logic [31:0] fill_word(logic [7:0] i);
    return {i ^ 8'h96, ~i, i + 8'h2d, i};
  endfunction

  // Expected cd_rdata once the model has taken the access
  function automatic logic [7:0] ref_byte(logic [2:0] sel);
    case (sel)
      cfgo_pkg::ADDR0:  return m_addr[7:0];
      cfgo_pkg::ADDR1:  return m_addr[15:8];
      cfgo_pkg::DATA0:  return m_hold[7:0];
      cfgo_pkg::DATA1:  return m_hold[15:8];
      cfgo_pkg::DATA2:  return m_hold[23:16];
      cfgo_pkg::DATA3:  return m_hold[31:24];
      cfgo_pkg::STATUS: return 8'h01;         // Only read with the engine idle
      default:          return 8'h00;
    endcase
  endfunction

  task automatic model_update(input logic [2:0] sel, input logic wr, input logic [7:0] wd);
    if (wr)
    begin
      case (sel)
        cfgo_pkg::ADDR0: m_addr[7:0]   = wd;
        cfgo_pkg::ADDR1: m_addr[15:8]  = wd;
        cfgo_pkg::DATA0: m_data[7:0]   = wd;
        cfgo_pkg::DATA1: m_data[15:8]  = wd;
        cfgo_pkg::DATA2: m_data[23:16] = wd;
        cfgo_pkg::DATA3: m_data[31:24] = wd;
        default: ;
      endcase
      if (sel == cfgo_pkg::DATA3)
      begin
        m_hold = m_data;                      // Sent word stays in hold
        m_mem[m_addr[7:0]] = m_data;
      end
    end
    else if (sel == cfgo_pkg::DATA0)
    begin
      m_hold = m_mem[m_addr[7:0]];            // Fetch on DATA0 read
    end
  endtask

  // One processor I/O cycle, stretched while wait_n is low
  task automatic io_access(input logic [15:0] port, input logic wr, input logic [7:0] wd,
                           input logic [3:0] dly, output logic [7:0] rd, output int waits);
    @(posedge clk);
    addr       <= port;
    cd_wdata   <= wd;
    iorq_n     <= 1'b0;
    rd_n       <= wr;
    wr_n       <= ~wr;
    trdy_delay <= dly;
    waits = 0;
    @(negedge clk);
    while (!wait_n)
    begin
      waits++;
      @(negedge clk);
    end
    rd = cd_rdata;                            // Value at the releasing edge
    @(posedge clk);
    iorq_n <= 1'b1;
    rd_n   <= 1'b1;
    wr_n   <= 1'b1;
  endtask

  task automatic reg_access(input logic [2:0] sel, input logic wr, input logic [7:0] wd,
                            input logic [3:0] dly);
    rd_rec_t rec;
    logic [7:0] got;
    int waits;
    rec.port = {rand_byte(), `CFGO_IO_BASE | {5'd0, sel}};  // High byte is don't care
    model_update(sel, wr, wd);
    io_access(rec.port, wr, wd, dly, got, waits);
    if (!wr)
    begin
      rec.got = got;
      rec.exp = ref_byte(sel);
      results.push_back(rec);
      -> result_ev;
    end
    if (!wr && sel == cfgo_pkg::DATA0 && waits == 0)
    begin
      errors++;
      $display("DATA0 read at port %h finished without wait_n going low", rec.port);
    end
  endtask

  task automatic wait_idle();
    logic [7:0] st;
    int waits;
    int tries;
    st = 8'h00;
    tries = 0;
    while (st != 8'h01 && tries < 40)
    begin
      io_access({8'h00, `CFGO_IO_BASE | 8'h06}, 1'b0, 8'h00, 4'd0, st, waits);
      tries++;
    end
    if (st != 8'h01)
    begin
      errors++;
      $display("Engine never returned to idle, STATUS stuck at %h", st);
    end
  endtask

  task automatic end_test(input string name);
    @(negedge clk);                           // Compare process drains first
    $display("%s: %0d errors", name, errors - test_err);
    test_err = errors;
  endtask

  // Compares each read against the reference
  initial
  begin
    rd_rec_t rec;
    forever
    begin
      @(result_ev);
      while (results.size() > 0)
      begin
        rec = results.pop_front();
        checks++;
        if (rec.got !== rec.exp)
        begin
          errors++;
          $display("[ERROR] cd_rdata at port %h: got %h, expected %h",
                   rec.port, rec.got, rec.exp);
        end
      end
    end
  end

  initial
  begin
    #(limit_ns);
    $display("Timeout after %0d ns, an access or config cycle never finished", limit_ns);
    $display("Test FAILED");
    $finish;
  end

  initial
  begin
    logic [7:0] lo;
    logic [7:0] got;
    logic [2:0] sel;
    logic       wr;
    int         waits;
    int         wr0;
    int         rd0;
    reset_n    = 1'b0;
    addr       = 16'h0000;
    cd_wdata   = 8'h00;
    rd_n       = 1'b1;
    wr_n       = 1'b1;
    iorq_n     = 1'b1;
    trdy_delay = 4'd0;
    m_addr     = 16'h0000;
    m_data     = 32'h0000_0000;
    m_hold     = 32'h0000_0000;
    for (int i = 0; i < 256; i++)
      m_mem[i] = fill_word(8'(i));
    repeat (16) @(posedge clk);
    reset_n <= 1'b1;

    @(negedge clk);
    if (wait_n !== 1'b1)
    begin
      errors++;
      $display("[ERROR] wait_n after reset: got %h, expected 1", wait_n);
    end
    if (cfg_req.irdy !== 1'b0)
    begin
      errors++;
      $display("[ERROR] cfg_req.irdy after reset: got %h, expected 0", cfg_req.irdy);
    end
    reg_access(cfgo_pkg::STATUS, 1'b0, 8'h00, 4'd0);
    end_test("[1] reset state");

    wr0 = wr_count;
    for (int s = 0; s < 6; s++)
      reg_access(3'(s), 1'b1, rand_byte(), rand_nib());   // ADDR0 through DATA3
    wait_idle();
    if (wr_count - wr0 != 1)
    begin
      errors++;
      $display("Expected one config write, target saw %0d", wr_count - wr0);
    end
    if (last_addr !== m_addr)
    begin
      errors++;
      $display("[ERROR] cfg_req.addr: got %h, expected %h", last_addr, m_addr);
    end
    if (last_wdata !== m_data)
    begin
      errors++;
      $display("[ERROR] cfg_req.wdata: got %h, expected %h", last_wdata, m_data);
    end
    if (target.mem[m_addr[7:0]] !== m_mem[m_addr[7:0]])
    begin
      errors++;
      $display("[ERROR] target mem[%h]: got %h, expected %h", m_addr[7:0],
               target.mem[m_addr[7:0]], m_mem[m_addr[7:0]]);
    end
    end_test("[2] config write");

    rd0 = rd_count;
    for (int r = 0; r < 4; r++)
    begin
      reg_access(cfgo_pkg::ADDR0, 1'b1, rand_byte(), 4'd0);
      reg_access(cfgo_pkg::ADDR1, 1'b1, rand_byte(), 4'd0);
      for (int s = 2; s < 6; s++)
        reg_access(3'(s), 1'b0, 8'h00, rand_nib());       // DATA0 fetches, rest from hold
    end
    if (rd_count - rd0 != 4)
    begin
      errors++;
      $display("Expected four config reads, target saw %0d", rd_count - rd0);
    end
    end_test("[3] config read");

    wr0 = wr_count;
    rd0 = rd_count;
    for (int s = 0; s < 5; s++)
      reg_access(3'(s), 1'b1, rand_byte(), 4'd0);         // Stops short of DATA3
    reg_access(cfgo_pkg::ADDR0, 1'b0, 8'h00, 4'd0);
    reg_access(cfgo_pkg::ADDR1, 1'b0, 8'h00, 4'd0);
    if (wr_count != wr0 || rd_count != rd0)
    begin
      errors++;
      $display("Address and low data writes started a config cycle");
    end
    end_test("[4] staging only");

    wr0 = wr_count;
    rd0 = rd_count;
    for (int p = 0; p < 4; p++)
    begin
      lo = (`CFGO_IO_BASE ^ (8'h08 << p)) | {5'd0, rand_bit(), rand_bit(), rand_bit()};
      io_access({rand_byte(), lo}, 1'b1, rand_byte(), 4'd0, got, waits);
      if (waits != 0)
      begin
        errors++;
        $display("Write to port %h outside the window lowered wait_n", lo);
      end
      io_access({rand_byte(), lo}, 1'b0, 8'h00, 4'd0, got, waits);
      if (got !== 8'h00)
      begin
        errors++;
        $display("[ERROR] cd_rdata outside window at %h: got %h, expected 00", lo, got);
      end
      if (waits != 0)
      begin
        errors++;
        $display("Read of port %h outside the window lowered wait_n", lo);
      end
    end
    if (wr_count != wr0 || rd_count != rd0)
    begin
      errors++;
      $display("Accesses outside the window caused config traffic");
    end
    reg_access(cfgo_pkg::ADDR0, 1'b0, 8'h00, 4'd0);       // Staging left alone
    end_test("[5] outside window");

    for (int n = 0; n < 200; n++)
    begin
      sel = {rand_bit(), rand_bit(), rand_bit()};
      wr  = rand_bit();
      if (sel == cfgo_pkg::STATUS)
        sel = cfgo_pkg::DATA0;                // STATUS varies while busy
      reg_access(sel, wr, rand_byte(), rand_nib());
    end
    wait_idle();
    for (int i = 0; i < 256; i++)
    begin
      if (target.mem[i] !== m_mem[i])
      begin
        errors++;
        $display("[ERROR] target mem[%h]: got %h, expected %h", 8'(i), target.mem[i], m_mem[i]);
      end
    end
    end_test("[6] random sequence");

    $display("Reads compared: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

//--- compile.f
+incdir+source
source/cfgo_pkg.sv
source/io_port_decode.sv
source/cfgo_reg_file.sv
source/cfgo_txn_engine.sv
source/io_readback.sv
source/cfgo_bridge_top.sv
test/cfg_target_model.sv
test/cfgo_bridge_tb.sv

//--- Makefile
TOP = cfgo_bridge_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/10ps -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps -j 0 -f compile.f \
		--top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
